/* rtl/mcr3_io_pkg.sv */
/*
 * Shared types and constants for the arcade I/O front end.
 * Imported by the loader, control, port and top-level modules.
 */
package mcr3_io_pkg;

	// ====================
	// Loader bus
	// ====================
	localparam int dl_addr_w = 25;

	typedef logic [7:0] dl_byte_t;

	// Loader index values
	localparam dl_byte_t IDX_ROM     = 8'd0;
	localparam dl_byte_t IDX_VARIANT = 8'd1;
	localparam dl_byte_t IDX_DIP     = 8'd254;

	// Region start addresses inside the ROM download
	localparam logic [dl_addr_w-1:0] SOUND_BASE  = 25'h000_E000;
	localparam logic [dl_addr_w-1:0] CSD_BASE    = 25'h001_0000;
	localparam logic [dl_addr_w-1:0] SPRITE_BASE = 25'h001_8000;
	localparam logic [dl_addr_w-1:0] BG_BASE     = 25'h002_8000;

	typedef enum logic [2:0] {
		REGION_MAIN,
		REGION_SOUND,
		REGION_CSD,
		REGION_SPRITE,
		REGION_BG
	} rom_region_t;

	typedef enum logic [1:0] {
		VARIANT_SPY,
		VARIANT_TURBO,
		VARIANT_CRATER,
		VARIANT_NONE
	} variant_t;

	// ====================
	// Player controls
	// ====================
	// Bit 0 is right, bit 10 is coin; all active high
	typedef struct packed {
		logic coin;
		logic shift;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	typedef logic [7:0] dial_t;

endpackage

/* rtl/mcr3_io_if.sv */
/*
 * Internal buses of the I/O front end: ROM region writes from the loader,
 * and the merged controls with variant and service switch.
 */
`timescale 1ns/1ps

interface rom_wr_if import mcr3_io_pkg::*; ();
	logic                  wr;
	rom_region_t           region;
	logic [dl_addr_w-1:0]  addr;
	dl_byte_t              data;

	// Loader side; one strobe per ROM byte
	modport source (output wr, output region, output addr, output data);
endinterface

interface ctrl_if import mcr3_io_pkg::*; ();
	player_t   merged;
	dial_t     dial;
	variant_t  variant;
	logic      service;

	// Buttons and dial come from the merge stage
	modport merge (output merged, output dial);

	// Variant and service switch come from the loader
	modport cfg (output variant, output service);

	modport sink (input merged, input dial, input variant, input service);
endinterface

/* rtl/rom_loader.sv */
/*
 * Decodes loader writes into ROM region writes, the game variant,
 * the DIP bytes and the ROM loaded flag.
 */
`timescale 1ns/1ps

module rom_loader import mcr3_io_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  dl_byte_t              ioctl_index,
	input  logic [dl_addr_w-1:0]  ioctl_addr,
	input  dl_byte_t              ioctl_dout,
	rom_wr_if.source              rom,
	ctrl_if.cfg                   ctrl,
	output dl_byte_t              dip_0,
	output logic                  rom_loaded
);

	logic                  rom_dl;
	logic                  rom_dl_q;
	rom_region_t           region_next;
	logic [dl_addr_w-1:0]  addr_next;
	logic [dl_addr_w-1:0]  csd_off;
	dl_byte_t              mod_byte;
	dl_byte_t              dip [8];

	assign rom_dl  = ioctl_download && (ioctl_index == IDX_ROM);
	assign csd_off = ioctl_addr - CSD_BASE;

	// ====================
	// Region decode
	// ====================
	always_comb begin
		if (ioctl_addr < SOUND_BASE) begin
			region_next = REGION_MAIN;
			addr_next   = ioctl_addr;
		end else if (ioctl_addr < CSD_BASE) begin
			region_next = REGION_SOUND;
			addr_next   = ioctl_addr - SOUND_BASE;
		end else if (ioctl_addr < SPRITE_BASE) begin
			// CSD ROM is 16 bit wide, bit 14 selects the byte lane
			region_next = REGION_CSD;
			addr_next   = {csd_off[dl_addr_w-1:15], csd_off[13:0], csd_off[14]};
		end else if (ioctl_addr < BG_BASE) begin
			region_next = REGION_SPRITE;
			addr_next   = ioctl_addr - SPRITE_BASE;
		end else begin
			region_next = REGION_BG;
			addr_next   = ioctl_addr - BG_BASE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom.wr <= 1'b0;
		end else begin
			rom.wr <= ioctl_wr && rom_dl;
		end
	end

	// Address and data only matter while wr is high
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && rom_dl) begin
			rom.region <= region_next;
			rom.addr   <= addr_next;
			rom.data   <= ioctl_dout;
		end
	end

	// ====================
	// Variant and DIPs
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mod_byte     <= 8'hff;
			ctrl.variant <= VARIANT_NONE;
		end else begin
			if (ioctl_wr && (ioctl_index == IDX_VARIANT)) begin
				mod_byte <= ioctl_dout;
			end
			// Second stage decodes the stored byte
			case (mod_byte)
				8'd0:    ctrl.variant <= VARIANT_SPY;
				8'd1:    ctrl.variant <= VARIANT_TURBO;
				8'd2:    ctrl.variant <= VARIANT_CRATER;
				default: ctrl.variant <= VARIANT_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				dip[i] <= 8'hff;
			end
		end else if (ioctl_wr && (ioctl_index == IDX_DIP) && (ioctl_addr[dl_addr_w-1:3] == '0)) begin
			dip[ioctl_addr[2:0]] <= ioctl_dout;
		end
	end

	assign dip_0        = dip[0];
	assign ctrl.service = dip[1][0];

	// Loaded once a ROM download has ended
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_dl_q   <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			rom_dl_q <= rom_dl;
			if (rom_dl_q && !rom_dl) begin
				rom_loaded <= 1'b1;
			end
		end
	end

endmodule

/* rtl/control_merge.sv */
/*
 * Merges both players' controls into one word and tracks which
 * of the two dials moved last.
 */
`timescale 1ns/1ps

module control_merge import mcr3_io_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst,
	input  player_t  player_1,
	input  player_t  player_2,
	input  dial_t    dial_1,
	input  dial_t    dial_2,
	ctrl_if.merge    ctrl
);

	dial_t  dial_1_q;
	dial_t  dial_2_q;
	logic   dial_sel;

	// Either player can press any button
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ctrl.merged <= '0;
		end else begin
			ctrl.merged <= player_1 | player_2;
		end
	end

	// ====================
	// Dial selection
	// ====================
	always_ff @(posedge clk_sys) begin
		dial_1_q <= dial_1;
		dial_2_q <= dial_2;
	end

	// Dial 1 is checked last so it wins a tie
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dial_sel <= 1'b0;
		end else begin
			if (dial_2_q != dial_2) begin
				dial_sel <= 1'b1;
			end
			if (dial_1_q != dial_1) begin
				dial_sel <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		ctrl.dial <= dial_sel ? dial_2 : dial_1;
	end

endmodule

/* rtl/input_port_mux.sv */
/*
 * Builds the five active-low game input bytes for the selected variant.
 * All outputs are registered one cycle after the control bus.
 */
`timescale 1ns/1ps

module input_port_mux import mcr3_io_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst,
	ctrl_if.sink      ctrl,
	input  dl_byte_t  dip_0,
	input  logic      steer_sel,
	output dl_byte_t  input_0,
	output dl_byte_t  input_1,
	output dl_byte_t  input_2,
	output dl_byte_t  input_3,
	output dl_byte_t  input_4,
	output logic      landscape
);

	player_t   m;
	dl_byte_t  in0_next;
	dl_byte_t  in1_next;
	dl_byte_t  in2_next;
	dl_byte_t  steer_byte;

	assign m = ctrl.merged;

	// Driving games read the dial only while steering is selected
	assign steer_byte = steer_sel ? ctrl.dial : 8'hff;

	always_comb begin
		in0_next = 8'hff;
		in1_next = 8'hff;
		in2_next = 8'hff;
		case (ctrl.variant)
			VARIANT_SPY: begin
				in0_next = ~{ctrl.service, 2'b00, m.shift, 3'b000, m.coin};
				in1_next = ~{3'b000, m.fire_a, m.fire_c, m.fire_e, m.fire_b, m.fire_d};
				in2_next = steer_byte;
			end
			VARIANT_TURBO: begin
				in0_next = ~{ctrl.service, 2'b00, m.shift, 3'b000, m.coin};
				in1_next = ~{3'b000, m.fire_e, m.fire_d, m.fire_c, m.fire_b, m.fire_a};
				in2_next = steer_byte;
			end
			VARIANT_CRATER: begin
				in0_next = ~{ctrl.service, 2'b00, m.fire_a, m.fire_e, m.shift, 1'b0, m.coin};
				in1_next = ctrl.dial;
				in2_next = ~{1'b0, m.fire_b, 1'b0, m.fire_c, m.down, m.up, 2'b00};
			end
			default: begin
				// No game selected, ports stay idle
			end
		endcase
	end

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			input_0   <= 8'hff;
			input_1   <= 8'hff;
			input_2   <= 8'hff;
			input_3   <= 8'hff;
			input_4   <= 8'hff;
			landscape <= 1'b0;
		end else begin
			input_0   <= in0_next;
			input_1   <= in1_next;
			input_2   <= in2_next;
			input_3   <= dip_0;
			input_4   <= 8'hff;
			landscape <= (ctrl.variant == VARIANT_CRATER);
		end
	end

endmodule

/* rtl/game_reset_gen.sv */
/*
 * Holds the game in reset until the ROM is loaded, then issues
 * a second single-cycle reset pulse RESET_HOLD cycles later.
 */
`timescale 1ns/1ps

module game_reset_gen #(
	parameter int RESET_HOLD = 65535
) (
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  reset_req,
	input  logic  rom_loaded,
	output logic  game_reset
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic [CNT_W-1:0]  hold_cnt;
	logic              cause;

	assign cause = reset_req || !rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hold_cnt   <= CNT_W'(RESET_HOLD);
			game_reset <= 1'b1;
		end else begin
			// Reload while any cause is present, else count down to zero
			if (cause) begin
				hold_cnt <= CNT_W'(RESET_HOLD);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			game_reset <= cause || (hold_cnt == CNT_W'(1));
		end
	end

endmodule

/* rtl/mcr3_io_top.sv */
/*
 * Top level of the I/O front end: loader decode, control merge,
 * input port mapping and game reset, connected through the internal buses.
 */
`timescale 1ns/1ps

module mcr3_io_top import mcr3_io_pkg::*; #(
	parameter int RESET_HOLD = 64
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  reset_req,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  dl_byte_t              ioctl_index,
	input  logic [dl_addr_w-1:0]  ioctl_addr,
	input  dl_byte_t              ioctl_dout,
	input  player_t               player_1,
	input  player_t               player_2,
	input  dial_t                 dial_1,
	input  dial_t                 dial_2,
	input  logic                  steer_sel,
	output logic                  rom_wr,
	output rom_region_t           rom_region,
	output logic [dl_addr_w-1:0]  rom_addr,
	output dl_byte_t              rom_data,
	output dl_byte_t              input_0,
	output dl_byte_t              input_1,
	output dl_byte_t              input_2,
	output dl_byte_t              input_3,
	output dl_byte_t              input_4,
	output logic                  landscape,
	output logic                  rom_loaded,
	output logic                  game_reset
);

	rom_wr_if  rom_bus ();
	ctrl_if    ctrl_bus ();
	dl_byte_t  dip_0;

	rom_loader u_rom_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom            (rom_bus.source),
		.ctrl           (ctrl_bus.cfg),
		.dip_0          (dip_0),
		.rom_loaded     (rom_loaded)
	);

	// ROM writes leave the block as plain ports
	assign rom_wr     = rom_bus.wr;
	assign rom_region = rom_bus.region;
	assign rom_addr   = rom_bus.addr;
	assign rom_data   = rom_bus.data;

	control_merge u_control_merge (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.player_1 (player_1),
		.player_2 (player_2),
		.dial_1   (dial_1),
		.dial_2   (dial_2),
		.ctrl     (ctrl_bus.merge)
	);

	input_port_mux u_input_port_mux (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ctrl      (ctrl_bus.sink),
		.dip_0     (dip_0),
		.steer_sel (steer_sel),
		.input_0   (input_0),
		.input_1   (input_1),
		.input_2   (input_2),
		.input_3   (input_3),
		.input_4   (input_4),
		.landscape (landscape)
	);

	game_reset_gen #(
		.RESET_HOLD (RESET_HOLD)
	) u_game_reset_gen (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.reset_req  (reset_req),
		.rom_loaded (rom_loaded),
		.game_reset (game_reset)
	);

endmodule

/* tb/io_assertions.sv */
/*
 * Protocol assertions for the I/O front end, bound into the top level.
 */
`timescale 1ns/1ps

module io_assertions import mcr3_io_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst,
	input  logic      rom_loaded,
	input  logic      game_reset,
	input  logic      rom_wr,
	input  logic      landscape,
	input  dl_byte_t  input_1,
	input  dial_t     dial_1,
	input  dial_t     dial_2
);

	int fail_count = 0;

	// Game stays in reset until a ROM has been loaded
	a_reset_until_loaded: assert property (@(posedge clk_sys) disable iff (rst)
		!rom_loaded |-> game_reset)
	else begin
		$error("game_reset low while no ROM is loaded");
		fail_count++;
	end

	a_rom_wr_single: assert property (@(posedge clk_sys) disable iff (rst)
		rom_wr |=> !rom_wr)
	else begin
		$error("rom_wr high for two cycles in a row");
		fail_count++;
	end

	// Crater layout shows one of the dial inputs once both have settled
	a_landscape_dial: assert property (@(posedge clk_sys) disable iff (rst)
		(landscape && $stable({dial_1, dial_2})
			&& ($past({dial_1, dial_2}) == $past({dial_1, dial_2}, 2))
			&& ({dial_1, dial_2} == $past({dial_1, dial_2}, 3)))
		|-> (input_1 == dial_1 || input_1 == dial_2))
	else begin
		$error("landscape high but input_1 does not follow the dial");
		fail_count++;
	end

endmodule

bind mcr3_io_top io_assertions u_assertions (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.rom_loaded (rom_loaded),
	.game_reset (game_reset),
	.rom_wr     (rom_wr),
	.landscape  (landscape),
	.input_1    (input_1),
	.dial_1     (dial_1),
	.dial_2     (dial_2)
);

/* tb/io_checker.sv */
/*
 * Testbench checker: compares DUT outputs with expected values and keeps
 * per-test and overall counts. Expected ROM writes are queued by the stimulus.
 */
`timescale 1ns/1ps

module io_checker import mcr3_io_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  rom_wr,
	input  rom_region_t           rom_region,
	input  logic [dl_addr_w-1:0]  rom_addr,
	input  dl_byte_t              rom_data,
	input  dl_byte_t              input_0,
	input  dl_byte_t              input_1,
	input  dl_byte_t              input_2,
	input  dl_byte_t              input_3,
	input  dl_byte_t              input_4,
	input  logic                  landscape,
	input  logic                  rom_loaded,
	input  logic                  game_reset
);

	typedef struct packed {
		rom_region_t           region;
		logic [dl_addr_w-1:0]  addr;
		dl_byte_t              data;
	} rom_wr_t;

	rom_wr_t  rom_expected [$];
	string    cur_test = "none";
	int       test_checks = 0;
	int       test_errors = 0;
	int       tests_run = 0;
	int       total_checks = 0;
	int       total_errors = 0;

	task automatic start_test(input string name);
		cur_test    = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		test_checks++;
		total_checks++;
		if (act !== exp) begin
			test_errors++;
			total_errors++;
			$display("[FAIL] %s: %s expected 'h%0h, actual 'h%0h", cur_test, what, exp, act);
		end
	endtask

	task automatic report_fault(input string msg);
		test_errors++;
		total_errors++;
		$display("Error in %s: %s", cur_test, msg);
	endtask

	task automatic expect_rom(input rom_region_t region, input logic [dl_addr_w-1:0] addr,
			input dl_byte_t data);
		rom_wr_t w;
		w.region = region;
		w.addr   = addr;
		w.data   = data;
		rom_expected.push_back(w);
	endtask

	// ====================
	// Port checks
	// ====================
	task automatic check_ports(input dl_byte_t e0, input dl_byte_t e1, input dl_byte_t e2,
			input dl_byte_t e3, input dl_byte_t e4, input logic eland);
		check_value("input_0", e0, input_0);
		check_value("input_1", e1, input_1);
		check_value("input_2", e2, input_2);
		check_value("input_3", e3, input_3);
		check_value("input_4", e4, input_4);
		check_value("landscape", eland, landscape);
	endtask

	task automatic check_game_reset(input logic exp);
		check_value("game_reset", exp, game_reset);
	endtask

	task automatic check_rom_loaded(input logic exp);
		check_value("rom_loaded", exp, rom_loaded);
	endtask

	task automatic check_rom_pulse(input logic exp);
		check_value("rom_wr", exp, rom_wr);
	endtask

	// Every ROM write strobe is matched against the oldest expected write
	always @(negedge clk_sys) begin : rom_write_monitor
		rom_wr_t w;
		if (!rst && rom_wr === 1'b1) begin
			if (rom_expected.size() == 0) begin
				report_fault("ROM write strobe seen with no write pending");
			end else begin
				w = rom_expected.pop_front();
				check_value("rom_region", w.region, rom_region);
				check_value("rom_addr", w.addr, rom_addr);
				check_value("rom_data", w.data, rom_data);
			end
		end
	end

	// ====================
	// Reporting
	// ====================
	task automatic end_test();
		if (rom_expected.size() != 0) begin
			report_fault($sformatf("%0d expected ROM writes never appeared",
				rom_expected.size()));
			rom_expected.delete();
		end
		tests_run++;
		$display("test %-16s %s, %0d checks, %0d errors", cur_test,
			(test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
	endtask

	task automatic print_counts(input int assert_fails);
		$display("tests %0d, checks %0d, check errors %0d, assertion failures %0d",
			tests_run, total_checks, total_errors, assert_fails);
	endtask

endmodule

/* tb/tb_mcr3_io.sv */
/*
 * Testbench for the I/O front end: drives loader, player and dial inputs,
 * computes expected results and hands them to the checker.
 */
`timescale 1ns/1ps

module tb_mcr3_io import mcr3_io_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_HOLD = 64;
	localparam int ROM_WRITES = 40;
	localparam int MAP_PAIRS  = 30;

	// Cycle budget of each test in order, doubled for the watchdog
	localparam int CYC_TOTAL = 16 + (ROM_WRITES * 2 + 8) + 2 * (RESET_HOLD + 16) + 32
		+ 3 * (MAP_PAIRS * 2 + 8) + 96;
	localparam int WATCHDOG_NS = 2 * CYC_TOTAL * CLK_PERIOD;

	logic                  clk_sys = 1'b0;
	logic                  rst;
	logic                  reset_req;
	logic                  ioctl_download;
	logic                  ioctl_wr;
	dl_byte_t              ioctl_index;
	logic [dl_addr_w-1:0]  ioctl_addr;
	dl_byte_t              ioctl_dout;
	player_t               player_1;
	player_t               player_2;
	dial_t                 dial_1;
	dial_t                 dial_2;
	logic                  steer_sel;
	logic                  rom_wr;
	rom_region_t           rom_region;
	logic [dl_addr_w-1:0]  rom_addr;
	dl_byte_t              rom_data;
	dl_byte_t              input_0;
	dl_byte_t              input_1;
	dl_byte_t              input_2;
	dl_byte_t              input_3;
	dl_byte_t              input_4;
	logic                  landscape;
	logic                  rom_loaded;
	logic                  game_reset;

	// Model state
	logic [31:0]  rng_state = 32'h8cb2_42a7;
	variant_t     cur_variant;
	player_t      merged;
	dial_t        exp_dial;
	dl_byte_t     exp_dip0;
	logic         exp_service;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	mcr3_io_top #(
		.RESET_HOLD (RESET_HOLD)
	) u_dut (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.reset_req      (reset_req),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.player_1       (player_1),
		.player_2       (player_2),
		.dial_1         (dial_1),
		.dial_2         (dial_2),
		.steer_sel      (steer_sel),
		.rom_wr         (rom_wr),
		.rom_region     (rom_region),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.input_0        (input_0),
		.input_1        (input_1),
		.input_2        (input_2),
		.input_3        (input_3),
		.input_4        (input_4),
		.landscape      (landscape),
		.rom_loaded     (rom_loaded),
		.game_reset     (game_reset)
	);

	io_checker u_chk (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.rom_wr     (rom_wr),
		.rom_region (rom_region),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.input_0    (input_0),
		.input_1    (input_1),
		.input_2    (input_2),
		.input_3    (input_3),
		.input_4    (input_4),
		.landscape  (landscape),
		.rom_loaded (rom_loaded),
		.game_reset (game_reset)
	);

	function automatic logic [31:0] rand32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// ====================
	// Reference model
	// ====================
	function automatic rom_region_t ref_region(input logic [dl_addr_w-1:0] a);
		if (a >= BG_BASE) return REGION_BG;
		if (a >= SPRITE_BASE) return REGION_SPRITE;
		if (a >= CSD_BASE) return REGION_CSD;
		if (a >= SOUND_BASE) return REGION_SOUND;
		return REGION_MAIN;
	endfunction

	function automatic logic [dl_addr_w-1:0] ref_addr(input logic [dl_addr_w-1:0] a);
		logic [dl_addr_w-1:0] off;
		case (ref_region(a))
			REGION_MAIN:   return a;
			REGION_SOUND:  return a - SOUND_BASE;
			REGION_CSD: begin
				// Offset bit 14 lands on bit 0, the rest shifts up
				off = a - CSD_BASE;
				return ((off & 25'h3fff) << 1) | ((off >> 14) & 25'h1);
			end
			REGION_SPRITE: return a - SPRITE_BASE;
			default:       return a - BG_BASE;
		endcase
	endfunction

	function automatic dl_byte_t ref_input_0(input variant_t v, input player_t m, input logic svc);
		dl_byte_t b;
		b = 8'h00;
		if (v == VARIANT_SPY || v == VARIANT_TURBO) begin
			b[7] = svc;
			b[4] = m.shift;
			b[0] = m.coin;
		end else if (v == VARIANT_CRATER) begin
			b[7] = svc;
			b[4] = m.fire_a;
			b[3] = m.fire_e;
			b[2] = m.shift;
			b[0] = m.coin;
		end
		return ~b;
	endfunction

	function automatic dl_byte_t ref_input_1(input variant_t v, input player_t m, input dial_t d);
		dl_byte_t b;
		b = 8'h00;
		case (v)
			VARIANT_SPY: b[4:0] = {m.fire_a, m.fire_c, m.fire_e, m.fire_b, m.fire_d};
			VARIANT_TURBO: b[4:0] = {m.fire_e, m.fire_d, m.fire_c, m.fire_b, m.fire_a};
			VARIANT_CRATER: return d;
			default: ;
		endcase
		return ~b;
	endfunction

	function automatic dl_byte_t ref_input_2(input variant_t v, input player_t m, input dial_t d,
			input logic steer);
		dl_byte_t b;
		b = 8'h00;
		if (v == VARIANT_SPY || v == VARIANT_TURBO) begin
			return steer ? d : 8'hff;
		end else if (v == VARIANT_CRATER) begin
			b[6] = m.fire_b;
			b[4] = m.fire_c;
			b[3] = m.down;
			b[2] = m.up;
		end
		return ~b;
	endfunction

	// ====================
	// Stimulus tasks
	// ====================
	// Called on a falling edge, returns on the next one with the strobe low
	task automatic loader_write(input dl_byte_t idx, input logic [dl_addr_w-1:0] a,
			input dl_byte_t d);
		ioctl_index = idx;
		ioctl_addr  = a;
		ioctl_dout  = d;
		ioctl_wr    = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic set_variant(input variant_t v);
		loader_write(IDX_VARIANT, '0, dl_byte_t'(v));
		cur_variant = v;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_model_ports();
		u_chk.check_ports(ref_input_0(cur_variant, merged, exp_service),
			ref_input_1(cur_variant, merged, exp_dial),
			ref_input_2(cur_variant, merged, exp_dial, steer_sel),
			exp_dip0, 8'hff, cur_variant == VARIANT_CRATER);
	endtask

	// Measures the distance from the last held reset cycle to the second pulse
	task automatic measure_reset_pulse();
		int n;
		n = 0;
		while (game_reset !== 1'b0 && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (game_reset !== 1'b0) begin
			u_chk.report_fault("game_reset never fell after the reset cause ended");
		end else begin
			// The first low cycle is already one cycle past the held reset
			n = 1;
			while (game_reset === 1'b0 && n < RESET_HOLD + 8) begin
				@(negedge clk_sys);
				n++;
			end
			u_chk.check_value("cycles before second pulse", RESET_HOLD, n);
			@(negedge clk_sys);
			u_chk.check_game_reset(1'b0);
			repeat (4) @(negedge clk_sys);
			u_chk.check_game_reset(1'b0);
		end
	endtask

	task automatic move_dials(input logic mv1, input logic mv2);
		if (mv2) begin
			dial_2 = dial_2 ^ (8'(rand32()) | 8'h01);
		end
		if (mv1) begin
			dial_1 = dial_1 ^ (8'(rand32()) | 8'h01);
		end
		exp_dial = mv1 ? dial_1 : dial_2;
		repeat (8) @(negedge clk_sys);
		check_model_ports();
	endtask

	task automatic run_mapping(input string name, input variant_t v);
		logic [31:0] t;
		u_chk.start_test(name);
		set_variant(v);
		for (int i = 0; i < MAP_PAIRS; i++) begin
			t = rand32();
			player_1  = player_t'(t[10:0]);
			player_2  = player_t'(t[21:11]);
			steer_sel = t[31];
			merged    = player_t'(t[10:0] | t[21:11]);
			repeat (2) @(negedge clk_sys);
			check_model_ports();
		end
		u_chk.end_test();
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin : main
		logic [31:0]           r;
		logic [dl_addr_w-1:0]  a;
		dl_byte_t              d;
		int                    assert_fails;

		rst            = 1'b1;
		reset_req      = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = IDX_ROM;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		player_1       = '0;
		player_2       = '0;
		dial_1         = 8'h5a;
		dial_2         = 8'ha5;
		steer_sel      = 1'b0;
		cur_variant    = VARIANT_NONE;
		merged         = '0;
		exp_dial       = 8'h5a;
		exp_dip0       = 8'hff;
		exp_service    = 1'b1;

		repeat (16) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);

		// Eight writes land in each region
		u_chk.start_test("rom_routing");
		ioctl_index    = IDX_ROM;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < ROM_WRITES; i++) begin
			r = rand32();
			case (i % 5)
				0:       a = 25'(r % 32'h0_E000);
				1:       a = 25'(32'h0_E000 + r % 32'h0_2000);
				2:       a = 25'(32'h1_0000 + r % 32'h0_8000);
				3:       a = 25'(32'h1_8000 + r % 32'h1_0000);
				default: a = 25'(32'h2_8000 + r % 32'h2_0000);
			endcase
			d = 8'(rand32());
			u_chk.expect_rom(ref_region(a), ref_addr(a), d);
			loader_write(IDX_ROM, a, d);
			u_chk.check_rom_pulse(1'b1);
			@(negedge clk_sys);
		end
		u_chk.end_test();

		u_chk.start_test("reset_sequence");
		u_chk.check_game_reset(1'b1);
		u_chk.check_rom_loaded(1'b0);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		u_chk.check_rom_loaded(1'b1);
		u_chk.check_game_reset(1'b1);
		measure_reset_pulse();
		reset_req = 1'b1;
		@(negedge clk_sys);
		u_chk.check_game_reset(1'b1);
		repeat (2) @(negedge clk_sys);
		reset_req = 1'b0;
		measure_reset_pulse();
		u_chk.end_test();

		// Address 8 is outside the DIP range and must leave byte 0 alone
		u_chk.start_test("dip_variant");
		check_model_ports();
		exp_dip0 = 8'(rand32());
		loader_write(IDX_DIP, 25'd0, exp_dip0);
		loader_write(IDX_DIP, 25'd1, 8'h01);
		exp_service = 1'b1;
		loader_write(IDX_DIP, 25'd5, 8'(rand32()));
		loader_write(IDX_DIP, 25'd8, ~exp_dip0);
		repeat (2) @(negedge clk_sys);
		check_model_ports();
		set_variant(VARIANT_SPY);
		check_model_ports();
		loader_write(IDX_DIP, 25'd1, 8'hfe);
		exp_service = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_model_ports();
		u_chk.end_test();

		run_mapping("map_spy", VARIANT_SPY);
		run_mapping("map_turbo", VARIANT_TURBO);
		run_mapping("map_crater", VARIANT_CRATER);

		u_chk.start_test("dial_select");
		set_variant(VARIANT_CRATER);
		move_dials(1'b0, 1'b1);
		move_dials(1'b1, 1'b0);
		move_dials(1'b1, 1'b1);
		set_variant(VARIANT_SPY);
		steer_sel = 1'b1;
		move_dials(1'b0, 1'b1);
		move_dials(1'b1, 1'b0);
		move_dials(1'b1, 1'b1);
		steer_sel = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_model_ports();
		u_chk.end_test();

		assert_fails = u_dut.u_assertions.fail_count;
		u_chk.print_counts(assert_fails);
		if (u_chk.total_errors == 0 && assert_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* sources.f */
rtl/mcr3_io_pkg.sv
rtl/mcr3_io_if.sv
rtl/rom_loader.sv
rtl/control_merge.sv
rtl/input_port_mux.sv
rtl/game_reset_gen.sv
rtl/mcr3_io_top.sv
tb/io_assertions.sv
tb/io_checker.sv
tb/tb_mcr3_io.sv

/* Bender.yml */
package:
  name: mcr3_io

sources:
  - rtl/mcr3_io_pkg.sv
  - rtl/mcr3_io_if.sv
  - rtl/rom_loader.sv
  - rtl/control_merge.sv
  - rtl/input_port_mux.sv
  - rtl/game_reset_gen.sv
  - rtl/mcr3_io_top.sv
  - target: test
    files:
      - tb/io_assertions.sv
      - tb/io_checker.sv
      - tb/tb_mcr3_io.sv
